/* src/fb_cfg.svh */
`ifndef FB_CFG_SVH
`define FB_CFG_SVH

// word and address widths
`define FB_DATA_W     64
`define FB_ADDR_W     32

// beats per burst, address steps by len * 8 bytes
`define FB_BURST_LEN  8

// clock crossing fifos, power of two
`define FB_FIFO_DEPTH 32
`define FB_LVL_W      ($clog2(`FB_FIFO_DEPTH) + 1)

`define FB_MEM_WORDS  64  // on-chip stand-in for the ddr

`endif

/* src/fb_pkg.sv */
`default_nettype none
`include "fb_cfg.svh"

package fb_pkg;

  typedef logic [`FB_DATA_W-1:0] fb_word_t;  // one user / memory word
  typedef logic [`FB_ADDR_W-1:0] fb_addr_t;  // byte address
  typedef logic [`FB_LVL_W-1:0]  fb_lvl_t;   // fifo fill count, 0..depth

  // burst memory controller states
  typedef enum logic [1:0] {
    idle,      // ready high, waiting for req
    wr_burst,  // pulling words out of the write fifo
    rd_burst,  // pushing words into the read fifo
    done       // finish pulse
  } mem_state_t;

endpackage

`default_nettype wire

/* src/burst_if.sv */
`timescale 1ns/1ps
`default_nettype none

// one burst channel between scheduler, memory and a fifo
interface burst_if import fb_pkg::*; ();

  logic          req;     // registered burst request
  fb_addr_t      addr;    // start byte address
  logic          ready;   // memory idle
  logic          finish;  // one cycle after the last beat
  logic          beat;    // a word moves this cycle
  wire fb_word_t data;    // driven by the fifo on wr, by memory on rd

  modport sched (output req, output addr, input ready, input finish);

  // memory side, data direction depends on which bus it sits on
  modport mem (input req, input addr, output ready, output finish,
               output beat, inout data);

  modport fifo (input beat, inout data);  // beat is the fifo enable

endinterface

`default_nettype wire

/* src/async_fifo.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fb_cfg.svh"

module async_fifo import fb_pkg::*; (
  input  wire           wr_clk,
  input  wire           rd_clk,
  input  wire           rst,       // active low, both sides
  input  wire           wr_en,
  input  wire fb_word_t wr_data,
  input  wire           rd_en,
  output fb_word_t      rd_data,   // show-ahead, valid while !empty
  output logic          full,
  output logic          empty,
  output fb_lvl_t       wr_level,  // fill seen from wr_clk
  output fb_lvl_t       rd_level   // fill seen from rd_clk
);

  localparam int AW = $clog2(`FB_FIFO_DEPTH);  // address bits, ptrs carry one more

  fb_word_t    mem [`FB_FIFO_DEPTH];
  logic [AW:0] wbin, wgray, wbin_nxt;
  logic [AW:0] rbin, rgray, rbin_nxt;
  logic [AW:0] rgray_s1, rgray_s2;  // read ptr into wr_clk
  logic [AW:0] wgray_s1, wgray_s2;  // write ptr into rd_clk
  logic        wr_ok, rd_ok;

  function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
    logic [AW:0] b;
    b[AW] = g[AW];
    for (int i = AW - 1; i >= 0; i--) begin
      b[i] = b[i + 1] ^ g[i];
    end
    return b;
  endfunction

  //////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////
  assign wr_ok    = wr_en && !full;              // overflow writes dropped
  assign wbin_nxt = wbin + {{AW{1'b0}}, wr_ok};

  always_ff @(posedge wr_clk or negedge rst) begin
    if (!rst) begin
      wbin     <= '0;
      wgray    <= '0;
      rgray_s1 <= '0;
      rgray_s2 <= '0;
    end else begin
      wbin     <= wbin_nxt;
      wgray    <= wbin_nxt ^ (wbin_nxt >> 1);
      rgray_s1 <= rgray;     // two flop sync
      rgray_s2 <= rgray_s1;
    end
  end

  always_ff @(posedge wr_clk) begin
    if (wr_ok) mem[wbin[AW-1:0]] <= wr_data;
  end

  // full when top two gray bits differ and the rest match
  assign full     = (wgray == {~rgray_s2[AW:AW-1], rgray_s2[AW-2:0]});
  assign wr_level = wbin - gray2bin(rgray_s2);  // pessimistic, never under-counts

  //////////////////////////////////////////////////
  // read side
  //////////////////////////////////////////////////
  assign rd_ok    = rd_en && !empty;
  assign rbin_nxt = rbin + {{AW{1'b0}}, rd_ok};

  always_ff @(posedge rd_clk or negedge rst) begin
    if (!rst) begin
      rbin     <= '0;
      rgray    <= '0;
      wgray_s1 <= '0;
      wgray_s2 <= '0;
    end else begin
      rbin     <= rbin_nxt;
      rgray    <= rbin_nxt ^ (rbin_nxt >> 1);
      wgray_s1 <= wgray;
      wgray_s2 <= wgray_s1;
    end
  end

  assign rd_data  = mem[rbin[AW-1:0]];          // first word falls through
  assign empty    = (rgray == wgray_s2);
  assign rd_level = gray2bin(wgray_s2) - rbin;

endmodule

`default_nettype wire

/* src/burst_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fb_cfg.svh"

module burst_scheduler import fb_pkg::*; (
  input  wire           ui_clk,
  input  wire           ui_rst,
  input  wire           ping_pong,    // two halves instead of one region
  input  wire fb_addr_t wr_b_addr,
  input  wire fb_addr_t wr_e_addr,
  input  wire fb_addr_t rd_b_addr,
  input  wire fb_addr_t rd_e_addr,
  input  wire           wr_rst,       // async restart, rising edge reloads base
  input  wire           rd_rst,
  input  wire           read_enable,
  input  wire fb_lvl_t  wr_level,     // write fifo fill, ui side
  input  wire fb_lvl_t  rd_level,     // read fifo fill, ui side
  burst_if.sched        wr_bus,
  burst_if.sched        rd_bus
);

  localparam fb_addr_t BURST_BYTES = fb_addr_t'(`FB_BURST_LEN * (`FB_DATA_W / 8));
  localparam fb_lvl_t  BURST_LVL   = fb_lvl_t'(`FB_BURST_LEN);
  localparam fb_lvl_t  FIFO_DEPTH  = fb_lvl_t'(`FB_FIFO_DEPTH);

  logic     wr_rst_s1, wr_rst_s2, rd_rst_s1, rd_rst_s2;
  logic     wr_restart, rd_restart;
  logic     addr_init;             // bases loaded once after reset
  logic     wr_half;               // half the writer is filling
  logic     wr_req_q, rd_req_q;
  fb_addr_t wr_addr_q, rd_addr_q;
  fb_addr_t wr_lin_last, wr_pp_last;
  fb_addr_t rd_lin_last, rd_pp_last;
  fb_lvl_t  rd_free;

  assign rd_free = FIFO_DEPTH - rd_level;

  // last burst start of a region, and of both halves together
  assign wr_lin_last = wr_e_addr - BURST_BYTES;
  assign wr_pp_last  = ((wr_e_addr - wr_b_addr) << 1) + wr_b_addr - BURST_BYTES;
  assign rd_lin_last = rd_e_addr - BURST_BYTES;
  assign rd_pp_last  = ((rd_e_addr - rd_b_addr) << 1) + rd_b_addr - BURST_BYTES;

  //////////////////////////////////////////////////
  // restart sync and edge detect
  //////////////////////////////////////////////////
  always_ff @(posedge ui_clk or negedge ui_rst) begin
    if (!ui_rst) begin
      wr_rst_s1 <= 1'b0;
      wr_rst_s2 <= 1'b0;
      rd_rst_s1 <= 1'b0;
      rd_rst_s2 <= 1'b0;
      addr_init <= 1'b0;
    end else begin
      wr_rst_s1 <= wr_rst;
      wr_rst_s2 <= wr_rst_s1;
      rd_rst_s1 <= rd_rst;
      rd_rst_s2 <= rd_rst_s1;
      addr_init <= 1'b1;
    end
  end

  assign wr_restart = wr_rst_s1 & ~wr_rst_s2;  // rising edges only
  assign rd_restart = rd_rst_s1 & ~rd_rst_s2;

  // request only after ready and the level were both seen
  always_ff @(posedge ui_clk or negedge ui_rst) begin
    if (!ui_rst) begin
      wr_req_q <= 1'b0;
      rd_req_q <= 1'b0;
    end else begin
      wr_req_q <= wr_bus.ready && (wr_level >= BURST_LVL);
      rd_req_q <= rd_bus.ready && read_enable && (rd_free >= BURST_LVL);
    end
  end

  //////////////////////////////////////////////////
  // write address walk
  //////////////////////////////////////////////////
  always_ff @(posedge ui_clk or negedge ui_rst) begin
    if (!ui_rst) begin
      wr_addr_q <= '0;
      wr_half   <= 1'b0;
    end else if (!addr_init || wr_restart) begin
      wr_addr_q <= wr_b_addr;
    end else if (wr_bus.finish) begin
      if (ping_pong) begin
        wr_addr_q <= (wr_addr_q >= wr_pp_last) ? wr_b_addr : wr_addr_q + BURST_BYTES;
        wr_half   <= (wr_addr_q >= wr_e_addr);  // half of the burst just done
      end else begin
        wr_addr_q <= (wr_addr_q >= wr_lin_last) ? wr_b_addr : wr_addr_q + BURST_BYTES;
      end
    end
  end

  //////////////////////////////////////////////////
  // read address walk
  //////////////////////////////////////////////////
  always_ff @(posedge ui_clk or negedge ui_rst) begin
    if (!ui_rst) begin
      rd_addr_q <= '0;
    end else if (!addr_init) begin
      rd_addr_q <= ping_pong ? rd_e_addr : rd_b_addr;  // start in the idle half
    end else if (rd_restart) begin
      rd_addr_q <= rd_b_addr;
    end else if (rd_bus.finish) begin
      if (ping_pong) begin
        if (rd_addr_q == rd_lin_last || rd_addr_q == rd_pp_last)
          rd_addr_q <= wr_half ? rd_b_addr : rd_e_addr;  // opposite the writer
        else
          rd_addr_q <= rd_addr_q + BURST_BYTES;
      end else begin
        rd_addr_q <= (rd_addr_q >= rd_lin_last) ? rd_b_addr : rd_addr_q + BURST_BYTES;
      end
    end
  end

  assign wr_bus.req  = wr_req_q;
  assign wr_bus.addr = wr_addr_q;
  assign rd_bus.req  = rd_req_q;
  assign rd_bus.addr = rd_addr_q;

endmodule

`default_nettype wire

/* src/burst_mem.sv */
`timescale 1ns/1ps
`default_nettype none
`include "fb_cfg.svh"

module burst_mem import fb_pkg::*; (
  input  wire  ui_clk,
  input  wire  ui_rst,
  burst_if.mem wr_bus,   // data comes from the write fifo
  burst_if.mem rd_bus    // data goes to the read fifo
);

  localparam int IDX_W    = $clog2(`FB_MEM_WORDS);
  localparam int CNT_W    = $clog2(`FB_BURST_LEN);
  localparam int BYTE_SH  = $clog2(`FB_DATA_W / 8);  // byte addr to word index
  localparam logic [CNT_W-1:0] LAST_BEAT = CNT_W'(`FB_BURST_LEN - 1);

  fb_word_t         mem [`FB_MEM_WORDS];
  mem_state_t       state;
  logic [CNT_W-1:0] beat_cnt;
  logic             wr_sel;              // 1 while serving the write bus
  logic [IDX_W-1:0] base_idx, cur_idx;

  always_ff @(posedge ui_clk or negedge ui_rst) begin
    if (!ui_rst) begin
      state    <= idle;
      beat_cnt <= '0;
      wr_sel   <= 1'b0;
    end else begin
      case (state)
        idle: begin
          beat_cnt <= '0;
          if (wr_bus.req) begin          // write wins a tie
            state  <= wr_burst;
            wr_sel <= 1'b1;
          end else if (rd_bus.req) begin
            state  <= rd_burst;
            wr_sel <= 1'b0;
          end
        end
        wr_burst, rd_burst: begin
          beat_cnt <= beat_cnt + 1'b1;
          if (beat_cnt == LAST_BEAT) state <= done;
        end
        default: state <= idle;          // done lasts one cycle
      endcase
    end
  end

  // start index latched on acceptance, wraps mod memory size
  always_ff @(posedge ui_clk) begin
    if (state == idle)
      base_idx <= wr_bus.req ? wr_bus.addr[BYTE_SH +: IDX_W] : rd_bus.addr[BYTE_SH +: IDX_W];
    if (state == wr_burst) mem[cur_idx] <= wr_bus.data;
  end

  assign cur_idx = base_idx + IDX_W'(beat_cnt);

  assign wr_bus.ready  = (state == idle);
  assign rd_bus.ready  = (state == idle);
  assign wr_bus.beat   = (state == wr_burst);   // fifo read enable
  assign rd_bus.beat   = (state == rd_burst);   // fifo write enable
  assign wr_bus.finish = (state == done) && wr_sel;
  assign rd_bus.finish = (state == done) && !wr_sel;
  assign rd_bus.data   = mem[cur_idx];

endmodule

`default_nettype wire

/* src/fb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_top import fb_pkg::*; (
  input  wire           ui_clk,
  input  wire           ui_rst,        // active low
  input  wire           user_wr_clk,
  input  wire           user_rd_clk,
  input  wire           ping_pong,
  input  wire fb_addr_t wr_b_addr,
  input  wire fb_addr_t wr_e_addr,
  input  wire fb_addr_t rd_b_addr,
  input  wire fb_addr_t rd_e_addr,
  input  wire           wr_rst,        // writer restart, active high
  input  wire           rd_rst,        // reader restart, active high
  input  wire           data_wren,
  input  wire fb_word_t data_wr,
  output logic          wr_full,
  input  wire           data_rden,
  output fb_word_t      data_rd,
  output logic          rd_empty,
  input  wire           read_enable
);

  fb_lvl_t wr_fifo_lvl;  // words waiting for a write burst
  fb_lvl_t rd_fifo_lvl;  // words parked in the read fifo

  burst_if wr_bus ();
  burst_if rd_bus ();

  // user -> ui_clk
  async_fifo wr_fifo_i (
    .wr_clk (user_wr_clk), .rd_clk (ui_clk), .rst (ui_rst & ~wr_rst),
    .wr_en (data_wren), .wr_data (data_wr), .rd_en (wr_bus.beat),
    .rd_data (wr_bus.data), .full (wr_full), .empty (),
    .wr_level (), .rd_level (wr_fifo_lvl)
  );

  // ui_clk -> user
  async_fifo rd_fifo_i (
    .wr_clk (ui_clk), .rd_clk (user_rd_clk), .rst (ui_rst & ~rd_rst),
    .wr_en (rd_bus.beat), .wr_data (rd_bus.data), .rd_en (data_rden),
    .rd_data (data_rd), .full (), .empty (rd_empty),
    .wr_level (rd_fifo_lvl), .rd_level ()
  );

  burst_scheduler sched_i (
    .ui_clk, .ui_rst, .ping_pong, .wr_b_addr, .wr_e_addr, .rd_b_addr, .rd_e_addr,
    .wr_rst, .rd_rst, .read_enable, .wr_level (wr_fifo_lvl), .rd_level (rd_fifo_lvl),
    .wr_bus (wr_bus), .rd_bus (rd_bus)
  );

  burst_mem mem_i (.ui_clk, .ui_rst, .wr_bus (wr_bus), .rd_bus (rd_bus));

endmodule

`default_nettype wire

/* sim/tb_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
  parameter real PERIOD = 100.0  // ns
) (
  output logic clk
);

  initial clk = 1'b0;
  always #(PERIOD / 2.0) clk = ~clk;  // free running, 50% duty

endmodule

`default_nettype wire

/* sim/fb_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fb_tb import fb_pkg::*; ();

  localparam int TDATA_WORDS = 352;                       // entries in the hex file
  localparam int UI_PERIOD   = 100;
  localparam int WATCHDOG_NS = TDATA_WORDS * 200 * UI_PERIOD;

  fb_word_t tdata [TDATA_WORDS];
  logic     ui_clk, user_wr_clk, user_rd_clk;
  logic     ui_rst, ping_pong, wr_rst, rd_rst, read_enable;
  logic     data_wren, data_rden, wr_full, rd_empty;
  fb_word_t data_wr, data_rd;
  fb_addr_t wr_b_addr, wr_e_addr, rd_b_addr, rd_e_addr;
  bit       saw_full;

  tb_clkgen #(.PERIOD(100.0)) ui_clk_gen (.clk(ui_clk));
  tb_clkgen #(.PERIOD(70.0))  wr_clk_gen (.clk(user_wr_clk));
  tb_clkgen #(.PERIOD(130.0)) rd_clk_gen (.clk(user_rd_clk));

  fb_top dut_i (.*);

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////
  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input fb_word_t exp, input fb_word_t act);
    if (exp !== act)
      stop_on_error($sformatf("error: %s expected %h actual %h", name, exp, act));
  endtask

  task automatic reset_dut(input logic pp);
    @(posedge ui_clk);
    ui_rst    <= 1'b0;
    ping_pong <= pp;               // mode is picked up while in reset
    repeat (2) @(posedge ui_clk);
    ui_rst    <= 1'b1;
    repeat (2) @(posedge ui_clk);
  endtask

  // push n words, holding each one until the fifo takes it
  task automatic write_frame(input int base, input int n);
    int sent;
    sent     = 0;
    saw_full = 1'b0;
    while (sent < n) begin
      @(posedge user_wr_clk);
      if (wr_full) saw_full = 1'b1;
      if (data_wren && !wr_full) sent++;  // taken at this edge
      data_wren <= (sent < n);
      if (sent < n) data_wr <= tdata[base + sent];
    end
  endtask

  // all words burst out to memory once the writer sees level 0
  task automatic wait_write_drained();
    do @(posedge user_wr_clk); while (dut_i.wr_fifo_i.wr_level != 0);
  endtask

  task automatic pulse_rd_rst();
    @(posedge ui_clk);
    rd_rst <= 1'b1;
    repeat (2) @(posedge ui_clk);
    rd_rst <= 1'b0;
    repeat (2) @(posedge ui_clk);
  endtask

  // prefetch one fifo worth, stop the reader, then drain with random gaps
  task automatic read_frame(input int base, input int n, input string name);
    int got;
    got = 0;
    @(posedge ui_clk);
    read_enable <= 1'b1;
    do @(posedge user_rd_clk); while (rd_empty);
    do @(posedge ui_clk); while (!dut_i.rd_fifo_i.full);  // 4 bursts parked
    read_enable <= 1'b0;
    while (got < n) begin
      @(posedge user_rd_clk);
      if (data_rden && !rd_empty) begin
        check_equal($sformatf("%s word %0d", name, got), tdata[base + got], data_rd);
        got++;
      end
      data_rden <= (got < n) && ($urandom % 3 != 0);
    end
  endtask

  //////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////
  initial begin : stimulus
    void'($urandom(32'h4cfccb60));
    $readmemh("sim/fb_testdata.hex", tdata);
    ui_rst      = 1'b0;
    ping_pong   = 1'b0;
    wr_rst      = 1'b0;
    rd_rst      = 1'b0;
    read_enable = 1'b0;
    data_wren   = 1'b0;
    data_rden   = 1'b0;
    data_wr     = '0;
    wr_b_addr   = 32'h0;
    wr_e_addr   = 32'h100;  // 256 bytes, 32 words per half
    rd_b_addr   = 32'h0;
    rd_e_addr   = 32'h100;

    reset_dut(1'b0);
    check_equal("reset rd_empty", 1, rd_empty);
    check_equal("reset wr_full", 0, wr_full);

    write_frame(0, 32);     // linear frame
    wait_write_drained();
    read_frame(32, 32, "linear");
    write_frame(64, 32);    // same region again after the wrap
    wait_write_drained();
    read_frame(96, 32, "wrap");

    reset_dut(1'b1);        // ping-pong steering
    write_frame(128, 32);
    wait_write_drained();
    pulse_rd_rst();
    read_frame(192, 32, "pingpong f0");
    write_frame(160, 32);   // second half, writer flips back
    wait_write_drained();
    read_frame(224, 32, "pingpong f1");

    reset_dut(1'b0);        // back-pressure, two regions worth
    write_frame(256, 64);   // 64 words only get through if full drops again
    check_equal("backpressure full seen", 1, saw_full);
    wait_write_drained();
    read_frame(320, 32, "backpressure");

    $display("Finished with no errors");
    $finish;
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    stop_on_error("timeout, the DUT stopped moving data");
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+src
src/fb_pkg.sv
src/burst_if.sv
src/async_fifo.sv
src/burst_scheduler.sv
src/burst_mem.sv
src/fb_top.sv
sim/tb_clkgen.sv
sim/fb_tb.sv

/* Bender.yml */
package:
  name: fb_frontend

sources:
  - include_dirs:
      - src
    files:
      - src/fb_pkg.sv
      - src/burst_if.sv
      - src/async_fifo.sv
      - src/burst_scheduler.sv
      - src/burst_mem.sv
      - src/fb_top.sv
  - target: simulation
    files:
      - sim/tb_clkgen.sv
      - sim/fb_tb.sv

/* sim/fb_testdata.hex */
// 16 words per line: linear wr, exp | wrap wr, exp | pingpong f0, f1, exp f0, exp f1
// then backpressure wr (64 words) and exp (its last 32 words)
2000 2001 2002 2003 2004 2005 2006 2007 2008 2009 200a 200b 200c 200d 200e 200f
2010 2011 2012 2013 2014 2015 2016 2017 2018 2019 201a 201b 201c 201d 201e 201f
2000 2001 2002 2003 2004 2005 2006 2007 2008 2009 200a 200b 200c 200d 200e 200f
2010 2011 2012 2013 2014 2015 2016 2017 2018 2019 201a 201b 201c 201d 201e 201f
3000 3001 3002 3003 3004 3005 3006 3007 3008 3009 300a 300b 300c 300d 300e 300f
3010 3011 3012 3013 3014 3015 3016 3017 3018 3019 301a 301b 301c 301d 301e 301f
3000 3001 3002 3003 3004 3005 3006 3007 3008 3009 300a 300b 300c 300d 300e 300f
3010 3011 3012 3013 3014 3015 3016 3017 3018 3019 301a 301b 301c 301d 301e 301f
4000 4001 4002 4003 4004 4005 4006 4007 4008 4009 400a 400b 400c 400d 400e 400f
4010 4011 4012 4013 4014 4015 4016 4017 4018 4019 401a 401b 401c 401d 401e 401f
4100 4101 4102 4103 4104 4105 4106 4107 4108 4109 410a 410b 410c 410d 410e 410f
4110 4111 4112 4113 4114 4115 4116 4117 4118 4119 411a 411b 411c 411d 411e 411f
4000 4001 4002 4003 4004 4005 4006 4007 4008 4009 400a 400b 400c 400d 400e 400f
4010 4011 4012 4013 4014 4015 4016 4017 4018 4019 401a 401b 401c 401d 401e 401f
4100 4101 4102 4103 4104 4105 4106 4107 4108 4109 410a 410b 410c 410d 410e 410f
4110 4111 4112 4113 4114 4115 4116 4117 4118 4119 411a 411b 411c 411d 411e 411f
5000 5001 5002 5003 5004 5005 5006 5007 5008 5009 500a 500b 500c 500d 500e 500f
5010 5011 5012 5013 5014 5015 5016 5017 5018 5019 501a 501b 501c 501d 501e 501f
5020 5021 5022 5023 5024 5025 5026 5027 5028 5029 502a 502b 502c 502d 502e 502f
5030 5031 5032 5033 5034 5035 5036 5037 5038 5039 503a 503b 503c 503d 503e 503f
5020 5021 5022 5023 5024 5025 5026 5027 5028 5029 502a 502b 502c 502d 502e 502f
5030 5031 5032 5033 5034 5035 5036 5037 5038 5039 503a 503b 503c 503d 503e 503f
